/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := cpu_tb
FILELIST  := tb.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := Done: no errors
SOURCES   := $(shell grep -v '^+' $(FILELIST)) rv_settings.svh

.PHONY: all run clean

all: run

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation failed"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* alu.sv */
`timescale 1ns/1ps

module alu (
    input  rv_pkg::ex_stage_t ex,
    input  rv_pkg::word_t     op1,
    input  rv_pkg::word_t     op2,
    output rv_pkg::word_t     result,
    output logic              taken,
    output rv_pkg::word_t     target
);
    import rv_pkg::*;

    logic eq;

    always_comb begin
        case (ex.ctrl.alu_op)
            ALU_SUB:    result = op1 - op2;
            ALU_AND:    result = op1 & op2;
            ALU_OR:     result = op1 | op2;
            ALU_XOR:    result = op1 ^ op2;
            ALU_SLT:    result = word_t'($signed(op1) < $signed(op2));
            ALU_PASS_B: result = op2;
            default:    result = op1 + op2;
        endcase
        // Link value
        if (ex.ctrl.br_op == BR_JAL) begin
            result = ex.pc + 32'd4;
        end
    end

    // Branches compare the two register operands
    assign eq     = (op1 == op2);
    assign taken  = (ex.ctrl.br_op == BR_EQ && eq) ||
                    (ex.ctrl.br_op == BR_NE && !eq) ||
                    (ex.ctrl.br_op == BR_JAL);
    assign target = ex.pc + ex.imm;

endmodule

/* cpu.sv */
`timescale 1ns/1ps

module cpu (
    input  logic          clk,
    input  logic          reset,
    output logic          imem_valid,
    output rv_pkg::word_t imem_addr,
    input  logic          imem_ready,
    input  rv_pkg::word_t imem_data,
    output logic          dmem_valid,
    output logic          dmem_we,
    output rv_pkg::word_t dmem_addr,
    output rv_pkg::word_t dmem_wdata,
    input  logic          dmem_ready,
    input  rv_pkg::word_t dmem_rdata
);
    import rv_pkg::*;

    word_t      id_pc;
    word_t      id_inst;
    logic       id_valid;
    ctrl_t      id_ctrl;
    word_t      id_imm;
    reg_addr_t  id_rs1;
    reg_addr_t  id_rs2;
    word_t      rf_rs1_data;
    word_t      rf_rs2_data;
    word_t      rs1_fwd;
    word_t      rs2_fwd;
    fwd_sel_t   fwd1;
    fwd_sel_t   fwd2;
    logic       stall;
    logic       flush;
    logic       freeze;
    ex_stage_t  ex;
    mem_stage_t mem;
    wb_stage_t  wb;
    word_t      ex_op2;
    word_t      ex_result;
    logic       taken;
    word_t      target;
    word_t      mem_value;

    //////////////////////////////
    // Fetch and decode
    //////////////////////////////

    fetch_unit i_fetch (
        .clk,
        .reset,
        .stall,
        .freeze,
        .redirect(flush),
        .target,
        .imem_valid,
        .imem_addr,
        .imem_ready,
        .imem_data,
        .id_pc,
        .id_inst,
        .id_valid
    );

    decoder i_decoder (
        .inst(id_inst),
        .valid(id_valid),
        .ctrl(id_ctrl),
        .imm(id_imm)
    );

    assign id_rs1 = id_inst[19:15];
    assign id_rs2 = id_inst[24:20];

    regfile i_regfile (
        .clk,
        .rs1(id_rs1),
        .rs2(id_rs2),
        .rs1_data(rf_rs1_data),
        .rs2_data(rf_rs2_data),
        .rd_en(wb.reg_en),
        .rd(wb.rd),
        .rd_data(wb.data)
    );

    hazard_control i_hazard (
        .clk,
        .reset,
        .id_rs1,
        .id_rs2,
        .ex,
        .mem,
        .taken,
        .dmem_ready,
        .fwd1,
        .fwd2,
        .stall,
        .flush,
        .freeze
    );

    // Load data straight off the port
    assign mem_value = mem.load ? dmem_rdata : mem.result;

    function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t reg_data);
        case (sel)
            FWD_EX:  return ex_result;
            FWD_MEM: return mem_value;
            default: return reg_data;
        endcase
    endfunction

    assign rs1_fwd = fwd_mux(fwd1, rf_rs1_data);
    assign rs2_fwd = fwd_mux(fwd2, rf_rs2_data);

    always_ff @(posedge clk) begin
        if (reset) begin
            ex.ctrl <= '0;
        end else if (!freeze) begin
            ex <= '{ctrl: id_ctrl, pc: id_pc, rs1_data: rs1_fwd, rs2_data: rs2_fwd,
                    imm: id_imm, rd: id_inst[11:7], rs1: id_rs1, rs2: id_rs2};
            // Bubble for a load-use stall or a taken branch
            if (stall || flush) begin
                ex.ctrl <= '0;
            end
        end
    end

    //////////////////////////////
    // Execute
    //////////////////////////////

    assign ex_op2 = (ex.ctrl.op2_sel == OP2_IMM) ? ex.imm : ex.rs2_data;

    alu i_alu (
        .ex,
        .op1(ex.rs1_data),
        .op2(ex_op2),
        .result(ex_result),
        .taken,
        .target
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            mem.reg_en <= 1'b0;
            mem.load   <= 1'b0;
            mem.store  <= 1'b0;
        end else if (!freeze) begin
            mem.reg_en     <= ex.ctrl.reg_en;
            mem.load       <= ex.ctrl.load;
            mem.store      <= ex.ctrl.store;
            mem.rd         <= ex.rd;
            mem.result     <= ex_result;
            mem.store_data <= ex.rs2_data;
        end
    end

    //////////////////////////////
    // Memory and write-back
    //////////////////////////////

    // Request held stable by freeze until dmem_ready
    assign dmem_valid = mem.load | mem.store;
    assign dmem_we    = mem.store;
    assign dmem_addr  = mem.result;
    assign dmem_wdata = mem.store_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb.reg_en <= 1'b0;
        end else if (!freeze) begin
            wb.reg_en <= mem.reg_en;
            wb.rd     <= mem.rd;
            wb.data   <= mem_value;
        end
    end

endmodule

/* cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;

    localparam int NUM_TESTS   = 8;
    localparam int BASE_TESTS  = 4;
    localparam int ROM_WORDS   = 64;
    localparam int RAM_WORDS   = 64;
    localparam int MAX_STORES  = 16;
    localparam int CYCLE_NS    = 8;
    localparam int RESET_CYCLES = 8;
    localparam int TEST_CYCLES = 400;
    localparam int TAIL_CYCLES = 30;

    // First fetch address after reset
    localparam logic [31:0] RESET_PC = 32'h0000_0000;

    // RV32I field values
    localparam int OPC_IMM  = 'b0010011;
    localparam int OPC_LOAD = 'b0000011;
    localparam int F3_ADD   = 0;
    localparam int F3_SLT   = 2;
    localparam int F3_XOR   = 4;
    localparam int F3_OR    = 6;
    localparam int F3_AND   = 7;
    localparam int F3_LW    = 2;
    localparam int F3_BEQ   = 0;
    localparam int F3_BNE   = 1;
    localparam int F7_SUB   = 32;
    localparam logic [31:0] NOP = 32'h0000_0013;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic        imem_valid;
    logic [31:0] imem_addr;
    logic        imem_ready = 1'b0;
    logic [31:0] imem_data = '0;
    logic        dmem_valid;
    logic        dmem_we;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_ready = 1'b0;
    logic [31:0] dmem_rdata = '0;

    // Test table
    logic [31:0] prog [NUM_TESTS][ROM_WORDS];
    int          prog_len [NUM_TESTS];
    logic        rand_ready [NUM_TESTS];
    logic [31:0] exp_addr [NUM_TESTS][MAX_STORES];
    logic [31:0] exp_data [NUM_TESTS][MAX_STORES];
    int          exp_cnt [NUM_TESTS];

    logic [31:0] rom [ROM_WORDS];
    logic [31:0] ram [RAM_WORDS];
    int          cur_row = 0;
    int          row = 0;
    int          seen = 0;
    int          errors = 0;
    int          failed = 0;
    logic        rand_on = 1'b0;
    integer      seed = 32'haaf4e7a3;

    cpu i_dut (
        .clk,
        .reset,
        .imem_valid,
        .imem_addr,
        .imem_ready,
        .imem_data,
        .dmem_valid,
        .dmem_we,
        .dmem_addr,
        .dmem_wdata,
        .dmem_ready,
        .dmem_rdata
    );

    always #(CYCLE_NS / 2) clk = ~clk;

    //////////////////////////////
    // Instruction encoders
    //////////////////////////////

    function automatic logic [31:0] r_format(input int f7, input int f3, input int rd,
                                             input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] i_format(input int opc, input int f3, input int rd,
                                             input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    // Always a word store
    function automatic logic [31:0] s_format(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_format(input int f3, input int rs1, input int rs2,
                                             input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] u_format(input int rd, input int imm);
        return {imm[19:0], rd[4:0], 7'b0110111};
    endfunction

    function automatic logic [31:0] j_format(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    // Background data for untouched RAM words
    function automatic logic [31:0] fill_word(input int idx);
        return 32'hfeed_0000 + idx;
    endfunction

    //////////////////////////////
    // Table building
    //////////////////////////////

    task automatic start_row(input int r);
        cur_row = r;
        prog_len[r] = 0;
        exp_cnt[r] = 0;
        rand_ready[r] = 1'b0;
    endtask

    task automatic emit(input logic [31:0] inst);
        prog[cur_row][prog_len[cur_row]] = inst;
        prog_len[cur_row]++;
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
        exp_addr[cur_row][exp_cnt[cur_row]] = addr;
        exp_data[cur_row][exp_cnt[cur_row]] = data;
        exp_cnt[cur_row]++;
    endtask

    task automatic build_table();
        int k;
        // ALU and immediates, then store x1..x12 at 0, 4, ...
        start_row(0);
        emit(i_format(OPC_IMM, F3_ADD, 1, 0, 100));
        emit(i_format(OPC_IMM, F3_ADD, 2, 0, -7));
        emit(u_format(3, 'h12345));
        emit(r_format(0, F3_ADD, 4, 1, 2));
        emit(r_format(F7_SUB, F3_ADD, 5, 2, 1));
        emit(r_format(0, F3_AND, 6, 1, 2));
        emit(r_format(0, F3_OR, 7, 1, 2));
        emit(r_format(0, F3_XOR, 8, 1, 2));
        emit(r_format(0, F3_SLT, 9, 2, 1));
        emit(r_format(0, F3_SLT, 10, 1, 2));
        emit(i_format(OPC_IMM, F3_ADD, 11, 1, -2048));
        emit(u_format(12, 'hfffff));
        emit(i_format(OPC_IMM, F3_ADD, 12, 12, 2047));
        for (k = 1; k <= 12; k++) begin
            emit(s_format(k, 0, 4 * (k - 1)));
        end
        emit(j_format(0, 0));
        expect_store(0, 32'h0000_0064);
        expect_store(4, 32'hffff_fff9);
        expect_store(8, 32'h1234_5000);
        expect_store(12, 32'h0000_005d);
        expect_store(16, 32'hffff_ff95);
        expect_store(20, 32'h0000_0060);
        expect_store(24, 32'hffff_fffd);
        expect_store(28, 32'hffff_ff9d);
        expect_store(32, 32'h0000_0001);
        expect_store(36, 32'h0000_0000);
        expect_store(40, 32'hffff_f864);
        expect_store(44, 32'hffff_f7ff);

        // Back-to-back dependencies and writes to x0
        start_row(1);
        emit(i_format(OPC_IMM, F3_ADD, 1, 0, 5));
        emit(i_format(OPC_IMM, F3_ADD, 1, 1, 3));
        emit(r_format(0, F3_ADD, 2, 1, 1));
        emit(i_format(OPC_IMM, F3_ADD, 0, 2, 1));
        emit(r_format(0, F3_ADD, 3, 2, 1));
        emit(r_format(F7_SUB, F3_ADD, 4, 3, 0));
        emit(s_format(4, 0, 0));
        emit(s_format(0, 0, 4));
        emit(i_format(OPC_IMM, F3_ADD, 5, 0, 64));
        emit(s_format(3, 5, 0));
        emit(i_format(OPC_IMM, F3_ADD, 6, 0, -1));
        emit(i_format(OPC_IMM, F3_ADD, 7, 0, 1));
        emit(s_format(6, 0, 8));
        emit(r_format(0, F3_ADD, 8, 7, 5));
        emit(s_format(8, 0, 12));
        emit(j_format(0, 0));
        expect_store(0, 32'd24);
        expect_store(4, 32'd0);
        expect_store(64, 32'd24);
        expect_store(8, 32'hffff_ffff);
        expect_store(12, 32'd65);

        // Load-use and store/load round trips
        start_row(2);
        emit(i_format(OPC_IMM, F3_ADD, 1, 0, 'h123));
        emit(u_format(2, 'habcde));
        emit(i_format(OPC_IMM, F3_ADD, 2, 2, 'h0f0));
        emit(s_format(2, 0, 16));
        emit(i_format(OPC_LOAD, F3_LW, 3, 0, 16));
        emit(i_format(OPC_IMM, F3_ADD, 4, 3, 1));
        emit(s_format(4, 0, 20));
        emit(i_format(OPC_LOAD, F3_LW, 5, 0, 20));
        emit(s_format(5, 0, 24));
        emit(i_format(OPC_LOAD, F3_LW, 6, 0, 16));
        emit(r_format(0, F3_ADD, 7, 6, 1));
        emit(s_format(7, 0, 28));
        emit(i_format(OPC_LOAD, F3_LW, 8, 0, 100));
        emit(s_format(8, 0, 32));
        emit(j_format(0, 0));
        expect_store(16, 32'habcd_e0f0);
        expect_store(20, 32'habcd_e0f1);
        expect_store(24, 32'habcd_e0f1);
        expect_store(28, 32'habcd_e213);
        expect_store(32, fill_word(25));

        // Branches and JAL; stores at 100..120 sit in branch shadows
        start_row(3);
        emit(i_format(OPC_IMM, F3_ADD, 1, 0, 7));
        emit(i_format(OPC_IMM, F3_ADD, 2, 0, 7));
        emit(i_format(OPC_IMM, F3_ADD, 3, 0, 9));
        emit(b_format(F3_BEQ, 1, 2, 12));
        emit(s_format(1, 0, 100));
        emit(s_format(1, 0, 104));
        emit(b_format(F3_BNE, 1, 2, 8));
        emit(s_format(3, 0, 0));
        emit(b_format(F3_BEQ, 1, 3, 8));
        emit(s_format(1, 0, 4));
        emit(b_format(F3_BNE, 1, 3, 12));
        emit(s_format(3, 0, 108));
        emit(s_format(3, 0, 112));
        emit(j_format(5, 12));
        emit(s_format(1, 0, 116));
        emit(s_format(1, 0, 120));
        emit(s_format(5, 0, 8));
        emit(i_format(OPC_IMM, F3_ADD, 6, 0, 3));
        emit(i_format(OPC_IMM, F3_ADD, 6, 6, -1));
        emit(s_format(6, 0, 12));
        emit(b_format(F3_BNE, 6, 0, -8));
        emit(j_format(0, 0));
        expect_store(0, 32'd9);
        expect_store(4, 32'd7);
        expect_store(8, 32'd56);
        expect_store(12, 32'd2);
        expect_store(12, 32'd1);
        expect_store(12, 32'd0);

        // Same programs again under random back-pressure
        for (k = BASE_TESTS; k < NUM_TESTS; k++) begin
            prog[k] = prog[k - BASE_TESTS];
            prog_len[k] = prog_len[k - BASE_TESTS];
            exp_addr[k] = exp_addr[k - BASE_TESTS];
            exp_data[k] = exp_data[k - BASE_TESTS];
            exp_cnt[k] = exp_cnt[k - BASE_TESTS];
            rand_ready[k] = 1'b1;
        end
    endtask

    //////////////////////////////
    // Memory models
    //////////////////////////////

    // Port inputs change 1 ns after the rising edge
    always @(posedge clk) begin
        #1;
        if (rand_on) begin
            imem_ready = (($random(seed) & 1) != 0);
            dmem_ready = (($random(seed) & 1) != 0);
        end else begin
            imem_ready = 1'b1;
            dmem_ready = 1'b1;
        end
        imem_data  = rom[imem_addr[7:2]];
        dmem_rdata = ram[dmem_addr[7:2]];
    end

    // Store handshakes are stable at the falling edge
    always @(negedge clk) begin
        if (reset) begin
            seen = 0;
            for (int i = 0; i < RAM_WORDS; i++) begin
                ram[i] = fill_word(i);
            end
        end else if (dmem_valid && dmem_ready && dmem_we) begin
            assert (seen < exp_cnt[row]) else begin
                $display("Test %0d made an extra store of %h to address %h at %0t ns",
                         row, dmem_wdata, dmem_addr, $time);
                errors++;
            end
            if (seen < exp_cnt[row]) begin
                assert (dmem_addr == exp_addr[row][seen]) else begin
                    $display("CHECK FAILED at %0t ns: test %0d store %0d address %h, expected %h",
                             $time, row, seen, dmem_addr, exp_addr[row][seen]);
                    errors++;
                end
                assert (dmem_wdata == exp_data[row][seen]) else begin
                    $display("CHECK FAILED at %0t ns: test %0d store %0d data %h, expected %h",
                             $time, row, seen, dmem_wdata, exp_data[row][seen]);
                    errors++;
                end
            end
            ram[dmem_addr[7:2]] = dmem_wdata;
            seen++;
        end
    end

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    task automatic run_row(input int r);
        int start_errors;
        int i;
        start_errors = errors;
        @(posedge clk);
        #1;
        reset = 1'b1;
        row = r;
        rand_on = rand_ready[r];
        for (i = 0; i < ROM_WORDS; i++) begin
            rom[i] = (i < prog_len[r]) ? prog[r][i] : NOP;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        // Both ports idle in the first cycle, fetch at the reset PC in the next
        @(negedge clk);
        assert (!imem_valid && !dmem_valid) else begin
            $display("CHECK FAILED at %0t ns: test %0d request %b/%b in first cycle, expected 0/0",
                     $time, r, imem_valid, dmem_valid);
            errors++;
        end
        @(negedge clk);
        assert (imem_valid && imem_addr == RESET_PC) else begin
            $display("CHECK FAILED at %0t ns: test %0d first fetch %b at %h, expected 1 at %h",
                     $time, r, imem_valid, imem_addr, RESET_PC);
            errors++;
        end
        while (seen < exp_cnt[r]) begin
            @(posedge clk);
        end
        // Final JAL spins here; any stray store shows up as an extra
        repeat (TAIL_CYCLES) @(posedge clk);
        if (errors == start_errors) begin
            $display("Test %0d (%s ready): passed, %0d stores", r,
                     rand_on ? "random" : "steady", seen);
        end else begin
            failed++;
            $display("Test %0d (%s ready): failed with %0d errors", r,
                     rand_on ? "random" : "steady", errors - start_errors);
        end
    endtask

    initial begin
        build_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_row(t);
        end
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 NUM_TESTS, NUM_TESTS - failed, failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(NUM_TESTS * TEST_CYCLES * CYCLE_NS);
        $display("Watchdog: the run timed out after %0d cycles", NUM_TESTS * TEST_CYCLES);
        $display("Done: errors found");
        $finish;
    end

endmodule

/* decoder.sv */
`timescale 1ns/1ps

module decoder (
    input  rv_pkg::word_t inst,
    input  logic          valid,
    output rv_pkg::ctrl_t ctrl,
    output rv_pkg::word_t imm
);
    import rv_pkg::*;

    logic [2:0] funct3;
    logic       funct7_5;

    assign funct3   = inst[14:12];
    assign funct7_5 = inst[30];

    always_comb begin
        // All enables off unless a known instruction says otherwise
        ctrl = '{reg_en: 1'b0, load: 1'b0, store: 1'b0, alu_op: ALU_ADD,
                 br_op: BR_NONE, op2_sel: OP2_RS2};
        imm  = {{20{inst[31]}}, inst[31:20]};
        if (valid) begin
            case (opcode_t'(inst[6:0]))
                OP: begin
                    ctrl.reg_en = 1'b1;
                    case (funct3)
                        3'b000:  ctrl.alu_op = funct7_5 ? ALU_SUB : ALU_ADD;
                        3'b010:  ctrl.alu_op = ALU_SLT;
                        3'b100:  ctrl.alu_op = ALU_XOR;
                        3'b110:  ctrl.alu_op = ALU_OR;
                        3'b111:  ctrl.alu_op = ALU_AND;
                        default: ctrl.reg_en = 1'b0;
                    endcase
                end
                OP_IMM: begin
                    ctrl.reg_en  = (funct3 == 3'b000);
                    ctrl.op2_sel = OP2_IMM;
                end
                LUI: begin
                    ctrl.reg_en  = 1'b1;
                    ctrl.alu_op  = ALU_PASS_B;
                    ctrl.op2_sel = OP2_IMM;
                    imm          = {inst[31:12], 12'b0};
                end
                LOAD: begin
                    ctrl.reg_en  = (funct3 == 3'b010);
                    ctrl.load    = (funct3 == 3'b010);
                    ctrl.op2_sel = OP2_IMM;
                end
                STORE: begin
                    ctrl.store   = (funct3 == 3'b010);
                    ctrl.op2_sel = OP2_IMM;
                    imm          = {{20{inst[31]}}, inst[31:25], inst[11:7]};
                end
                BRANCH: begin
                    if (funct3 == 3'b000) begin
                        ctrl.br_op = BR_EQ;
                    end else if (funct3 == 3'b001) begin
                        ctrl.br_op = BR_NE;
                    end
                    imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
                end
                JAL: begin
                    ctrl.reg_en = 1'b1;
                    ctrl.br_op  = BR_JAL;
                    imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
                end
                default: ;
            endcase
        end
    end

endmodule

/* fetch_unit.sv */
`timescale 1ns/1ps
`include "rv_settings.svh"

module fetch_unit (
    input  logic          clk,
    input  logic          reset,
    input  logic          stall,
    input  logic          freeze,
    input  logic          redirect,
    input  rv_pkg::word_t target,
    output logic          imem_valid,
    output rv_pkg::word_t imem_addr,
    input  logic          imem_ready,
    input  rv_pkg::word_t imem_data,
    output rv_pkg::word_t id_pc,
    output rv_pkg::word_t id_inst,
    output logic          id_valid
);
    import rv_pkg::*;

    word_t pc;
    logic  active;
    logic  accept;

    // No request in the cycle right after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
        end else begin
            active <= 1'b1;
        end
    end

    // Only fetch when decode can take the word
    assign imem_valid = active & ~stall & ~freeze & ~redirect;
    assign imem_addr  = pc;
    assign accept     = imem_valid & imem_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= `RV_RESET_PC;
            id_valid <= 1'b0;
            id_inst  <= '0;
        end else if (freeze) begin
            // Hold everything
        end else if (redirect) begin
            pc       <= target;
            id_valid <= 1'b0;
            id_inst  <= '0;
        end else if (!stall) begin
            id_valid <= accept;
            id_inst  <= accept ? imem_data : '0;
            id_pc    <= pc;
            if (accept) begin
                pc <= pc + 32'd4;
            end
        end
    end

endmodule

/* hazard_control.sv */
`timescale 1ns/1ps

module hazard_control (
    input  logic               clk,
    input  logic               reset,
    input  rv_pkg::reg_addr_t  id_rs1,
    input  rv_pkg::reg_addr_t  id_rs2,
    input  rv_pkg::ex_stage_t  ex,
    input  rv_pkg::mem_stage_t mem,
    input  logic               taken,
    input  logic               dmem_ready,
    output rv_pkg::fwd_sel_t   fwd1,
    output rv_pkg::fwd_sel_t   fwd2,
    output logic               stall,
    output logic               flush,
    output logic               freeze
);
    import rv_pkg::*;

    logic load_use;
    logic stalled_q;

    // Newest producer wins, x0 never forwards
    function automatic fwd_sel_t pick(input reg_addr_t rs);
        if (rs != '0 && ex.ctrl.reg_en && !ex.ctrl.load && ex.rd == rs) begin
            return FWD_EX;
        end else if (rs != '0 && mem.reg_en && mem.rd == rs) begin
            return FWD_MEM;
        end
        return FWD_REG;
    endfunction

    assign fwd1 = pick(id_rs1);
    assign fwd2 = pick(id_rs2);

    //////////////////////////////
    // Stall, flush and freeze
    //////////////////////////////

    // Loaded data is not there until the memory stage
    assign load_use = ex.ctrl.load && ex.rd != '0 &&
                      (ex.rd == id_rs1 || ex.rd == id_rs2);

    // One bubble per load is enough
    assign stall  = load_use & ~stalled_q;
    assign flush  = taken;
    assign freeze = (mem.load | mem.store) & ~dmem_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            stalled_q <= 1'b0;
        end else if (!freeze) begin
            stalled_q <= stall;
        end
    end

endmodule

/* regfile.sv */
`timescale 1ns/1ps
`include "rv_settings.svh"

module regfile (
    input  logic              clk,
    input  rv_pkg::reg_addr_t rs1,
    input  rv_pkg::reg_addr_t rs2,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data,
    input  logic              rd_en,
    input  rv_pkg::reg_addr_t rd,
    input  rv_pkg::word_t     rd_data
);
    import rv_pkg::*;

    word_t regs [`RV_NUM_REGS];

    always_ff @(posedge clk) begin
        if (rd_en && rd != '0) begin
            regs[rd] <= rd_data;
        end
    end

    // Write-through so decode sees the value being written back
    assign rs1_data = (rs1 == '0) ? '0 :
                      (rd_en && rd == rs1) ? rd_data : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 :
                      (rd_en && rd == rs2) ? rd_data : regs[rs2];

endmodule

/* rv_pkg.sv */
`include "rv_settings.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [4:0] reg_addr_t;

    // Major opcodes, RV32I encoding
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_t;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_JAL
    } br_op_t;

    typedef enum logic {
        OP2_RS2,
        OP2_IMM
    } op2_sel_t;

    // Source of a register operand
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_EX,
        FWD_MEM
    } fwd_sel_t;

    typedef struct packed {
        logic     reg_en;
        logic     load;
        logic     store;
        alu_op_t  alu_op;
        br_op_t   br_op;
        op2_sel_t op2_sel;
    } ctrl_t;

    // Decode to execute
    typedef struct packed {
        ctrl_t     ctrl;
        word_t     pc;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
    } ex_stage_t;

    // Execute to memory
    typedef struct packed {
        logic      reg_en;
        logic      load;
        logic      store;
        reg_addr_t rd;
        word_t     result;
        word_t     store_data;
    } mem_stage_t;

    // Memory to write-back
    typedef struct packed {
        logic      reg_en;
        reg_addr_t rd;
        word_t     data;
    } wb_stage_t;

endpackage

/* rv_settings.svh */
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// PC loaded by reset
`define RV_RESET_PC 32'h0000_0000

// Architectural register count
`define RV_NUM_REGS 32

// Data and instruction width
`define RV_XLEN 32

`endif

/* tb.f */
+incdir+.
rv_pkg.sv
fetch_unit.sv
decoder.sv
regfile.sv
alu.sv
hazard_control.sv
cpu.sv
cpu_tb.sv
